/* include/exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Data word width
`define EXEC_RW 16

// Status flag count and bit positions inside the flag word
`define EXEC_FLAG_CNT 5
`define EXEC_FLAG_C 0
`define EXEC_FLAG_Z 1
`define EXEC_FLAG_N 2
`define EXEC_FLAG_O 3
`define EXEC_FLAG_P 4

// Jump code width, top bit enables the jump
`define EXEC_JUMP_W 5

`define EXEC_PC_RESET 16'h0000

`endif

/* hdl/exec_pkg.sv */
`include "exec_macros.svh"

package exec_pkg;

    // ALU operation select
    typedef enum logic [3:0] {
        PASS_R = 4'd0,
        ADD    = 4'd1,
        SUB    = 4'd2,
        AND    = 4'd3,
        OR     = 4'd4,
        XOR    = 4'd5,
        SHL    = 4'd6,
        SHR    = 4'd7
    } alu_mode_t;

    // Conditional jump codes, enable bit on top
    typedef enum logic [`EXEC_JUMP_W-1:0] {
        NONE   = 5'b00000,
        UNCOND = 5'b10000,
        CARRY  = 5'b10001,
        EQUAL  = 5'b10010,
        LT     = 5'b10011,
        GT     = 5'b10100,
        LE     = 5'b10101,
        GE     = 5'b10110,
        NE     = 5'b10111,
        OVF    = 5'b11000,
        PAR    = 5'b11001,
        GTU    = 5'b11010,
        GEU    = 5'b11011,
        LEU    = 5'b11100
    } jump_code_t;

    typedef logic [`EXEC_FLAG_CNT-1:0] flags_t;

endpackage

/* hdl/exec_alu.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_alu (
    input  logic [`EXEC_RW-1:0] i_l,
    input  logic [`EXEC_RW-1:0] i_r,
    input  exec_pkg::alu_mode_t i_mode,
    input  logic                i_carry,
    output logic [`EXEC_RW-1:0] o_out,
    output exec_pkg::flags_t    o_flags
);

    localparam int SHW = $clog2(`EXEC_RW);
    localparam int MSB = `EXEC_RW - 1;

    logic [`EXEC_RW:0] wide;
    logic [`EXEC_RW:0] shr_tmp;
    logic [SHW-1:0]    shamt;
    logic              carry;
    logic              ovf;

    assign shamt = i_r[SHW-1:0];

    always_comb begin
        wide    = '0;
        shr_tmp = '0;
        carry   = 1'b0;
        ovf     = 1'b0;
        case (i_mode)
            exec_pkg::PASS_R: wide = {1'b0, i_r};
            exec_pkg::ADD: begin
                wide  = {1'b0, i_l} + {1'b0, i_r} + {{`EXEC_RW{1'b0}}, i_carry};
                carry = wide[`EXEC_RW];
                ovf   = (i_l[MSB] == i_r[MSB]) & (wide[MSB] != i_l[MSB]);
            end
            exec_pkg::SUB: begin
                // Carry holds the borrow, so GEU reads as carry clear
                wide  = {1'b0, i_l} - {1'b0, i_r} - {{`EXEC_RW{1'b0}}, i_carry};
                carry = wide[`EXEC_RW];
                ovf   = (i_l[MSB] != i_r[MSB]) & (wide[MSB] != i_l[MSB]);
            end
            exec_pkg::AND: wide = {1'b0, i_l & i_r};
            exec_pkg::OR:  wide = {1'b0, i_l | i_r};
            exec_pkg::XOR: wide = {1'b0, i_l ^ i_r};
            exec_pkg::SHL: begin
                // Last bit shifted out lands in the extra top bit
                wide  = {1'b0, i_l} << shamt;
                carry = wide[`EXEC_RW];
            end
            exec_pkg::SHR: begin
                shr_tmp = {i_l, 1'b0} >> shamt;
                wide    = {1'b0, shr_tmp[`EXEC_RW:1]};
                carry   = shr_tmp[0];
            end
            default: wide = '0;
        endcase
    end

    assign o_out = wide[`EXEC_RW-1:0];

    always_comb begin
        o_flags                = '0;
        o_flags[`EXEC_FLAG_C]  = carry;
        o_flags[`EXEC_FLAG_Z]  = (o_out == '0);
        o_flags[`EXEC_FLAG_N]  = o_out[MSB];
        o_flags[`EXEC_FLAG_O]  = ovf;
        // Set for an even number of ones
        o_flags[`EXEC_FLAG_P]  = ~^o_out;
    end

endmodule

/* hdl/exec_branch_unit.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_branch_unit (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_exec_fire,
    input  logic [`EXEC_RW-1:0]    i_alu_out,
    input  exec_pkg::flags_t       i_alu_flags,
    input  logic                   i_flags_ie,
    input  logic                   i_pc_inc,
    input  logic                   i_pc_ie,
    input  logic                   i_jmp_predict,
    input  exec_pkg::jump_code_t   i_jump_code,
    output exec_pkg::flags_t       o_flags_q,
    output logic [`EXEC_RW-1:0]    o_pc,
    output logic                   o_flush
);

    logic jump_valid;
    logic jump_taken;
    logic flag_c, flag_z, flag_n, flag_o, flag_p;

    assign flag_c = o_flags_q[`EXEC_FLAG_C];
    assign flag_z = o_flags_q[`EXEC_FLAG_Z];
    assign flag_n = o_flags_q[`EXEC_FLAG_N];
    assign flag_o = o_flags_q[`EXEC_FLAG_O];
    assign flag_p = o_flags_q[`EXEC_FLAG_P];

    assign jump_valid = i_jump_code[`EXEC_JUMP_W-1];

    // Condition evaluated against flags stored by earlier instructions
    always_comb begin
        case (i_jump_code)
            exec_pkg::UNCOND: jump_taken = 1'b1;
            exec_pkg::CARRY:  jump_taken = flag_c;
            exec_pkg::EQUAL:  jump_taken = flag_z;
            exec_pkg::LT:     jump_taken = flag_n;
            exec_pkg::GT:     jump_taken = ~(flag_n | flag_z);
            exec_pkg::LE:     jump_taken = flag_n | flag_z;
            exec_pkg::GE:     jump_taken = ~flag_n;
            exec_pkg::NE:     jump_taken = ~flag_z;
            exec_pkg::OVF:    jump_taken = flag_o;
            exec_pkg::PAR:    jump_taken = flag_p;
            exec_pkg::GTU:    jump_taken = ~(flag_c | flag_z);
            exec_pkg::GEU:    jump_taken = ~flag_c;
            exec_pkg::LEU:    jump_taken = flag_c | flag_z;
            default:          jump_taken = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flags_q <= '0;
        end else if (i_exec_fire & i_flags_ie) begin
            o_flags_q <= i_alu_flags;
        end
    end

    // Jump target comes from the ALU result
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc <= `EXEC_PC_RESET;
        end else if (i_exec_fire) begin
            if ((jump_valid & jump_taken) | i_pc_ie) begin
                o_pc <= i_alu_out;
            end else if ((jump_valid & ~jump_taken) | i_pc_inc) begin
                o_pc <= o_pc + 1'b1;
            end
        end
    end

    // Fetch guessed wrong, or PC was written directly
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flush <= 1'b0;
        end else begin
            o_flush <= i_exec_fire & ((jump_valid & (jump_taken ^ i_jmp_predict)) | i_pc_ie);
        end
    end

endmodule

/* hdl/exec_pipe_ctrl.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_pipe_ctrl (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_submit,
    input  logic                i_flush,
    input  logic                i_next_ready,
    input  logic [`EXEC_RW-1:0] i_result,
    input  logic [7:0]          i_rf_ie,
    output logic                o_ready,
    output logic                o_exec_fire,
    output logic [`EXEC_RW-1:0] o_data,
    output logic [7:0]          o_reg_ie,
    output logic                o_submit
);

    logic in_valid;
    logic hold_valid;
    logic instr_valid;

    // A flushed instruction is dropped without execution
    assign in_valid    = i_submit & ~i_flush;
    assign instr_valid = in_valid | (hold_valid & ~i_submit & ~i_flush);
    assign o_exec_fire = i_next_ready & instr_valid;

    // Ready when idle or when the current one leaves this cycle
    assign o_ready = o_exec_fire | ~instr_valid;

    // Remembers an instruction stalled by the next stage
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            hold_valid <= 1'b0;
        end else if (i_flush | o_exec_fire) begin
            hold_valid <= 1'b0;
        end else if (in_valid) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_submit <= 1'b0;
        end else begin
            o_submit <= o_exec_fire;
        end
    end

    // Result and destination mask toward the next stage
    always_ff @(posedge i_clk) begin
        if (o_exec_fire) begin
            o_data   <= i_result;
            o_reg_ie <= i_rf_ie;
        end
    end

endmodule

/* hdl/exec_stage.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_stage (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_submit,
    input  logic                 i_flush,
    input  logic                 i_next_ready,
    input  logic [`EXEC_RW-1:0]  i_l_operand,
    input  logic [`EXEC_RW-1:0]  i_r_operand,
    input  logic [`EXEC_RW-1:0]  i_imm,
    input  logic                 c_r_bus_imm,
    input  logic                 c_alu_carry_en,
    input  logic                 c_alu_flags_ie,
    input  logic                 c_pc_inc,
    input  logic                 c_pc_ie,
    input  logic                 i_jmp_predict,
    input  exec_pkg::alu_mode_t  c_alu_mode,
    input  exec_pkg::jump_code_t c_jump_code,
    input  logic [7:0]           c_rf_ie,
    output logic                 o_ready,
    output logic                 o_submit,
    output logic [`EXEC_RW-1:0]  o_data,
    output logic [7:0]           o_reg_ie,
    output logic                 o_flush,
    output logic                 o_pc_update,
    output logic [`EXEC_RW-1:0]  o_exec_pc
);

    logic [`EXEC_RW-1:0] alu_r_bus;
    logic [`EXEC_RW-1:0] alu_out;
    logic                alu_carry_in;
    exec_pkg::flags_t    alu_flags;
    exec_pkg::flags_t    flags_q;
    logic                exec_fire;

    // Right operand is either the register value or the immediate
    assign alu_r_bus    = c_r_bus_imm ? i_imm : i_r_operand;
    assign alu_carry_in = flags_q[`EXEC_FLAG_C] & c_alu_carry_en;

    // Fetch sees the PC before this cycle's update
    assign o_pc_update = exec_fire;

    exec_alu u_alu (
        .i_l     (i_l_operand),
        .i_r     (alu_r_bus),
        .i_mode  (c_alu_mode),
        .i_carry (alu_carry_in),
        .o_out   (alu_out),
        .o_flags (alu_flags)
    );

    exec_branch_unit u_branch (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_exec_fire   (exec_fire),
        .i_alu_out     (alu_out),
        .i_alu_flags   (alu_flags),
        .i_flags_ie    (c_alu_flags_ie),
        .i_pc_inc      (c_pc_inc),
        .i_pc_ie       (c_pc_ie),
        .i_jmp_predict (i_jmp_predict),
        .i_jump_code   (c_jump_code),
        .o_flags_q     (flags_q),
        .o_pc          (o_exec_pc),
        .o_flush       (o_flush)
    );

    exec_pipe_ctrl u_pipe (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_submit     (i_submit),
        .i_flush      (i_flush),
        .i_next_ready (i_next_ready),
        .i_result     (alu_out),
        .i_rf_ie      (c_rf_ie),
        .o_ready      (o_ready),
        .o_exec_fire  (exec_fire),
        .o_data       (o_data),
        .o_reg_ie     (o_reg_ie),
        .o_submit     (o_submit)
    );

endmodule

/* verification/exec_checker.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_checker (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_final,
    input  logic                 i_submit,
    input  logic                 i_flush,
    input  logic                 i_next_ready,
    input  logic [`EXEC_RW-1:0]  i_l_operand,
    input  logic [`EXEC_RW-1:0]  i_r_operand,
    input  logic [`EXEC_RW-1:0]  i_imm,
    input  logic                 i_r_bus_imm,
    input  logic                 i_carry_en,
    input  logic                 i_flags_ie,
    input  logic                 i_pc_inc,
    input  logic                 i_pc_ie,
    input  logic                 i_jmp_predict,
    input  exec_pkg::alu_mode_t  i_alu_mode,
    input  exec_pkg::jump_code_t i_jump_code,
    input  logic [7:0]           i_rf_ie,
    input  logic                 i_ready,
    input  logic                 i_out_submit,
    input  logic [`EXEC_RW-1:0]  i_data,
    input  logic [7:0]           i_reg_ie,
    input  logic                 i_out_flush,
    input  logic                 i_pc_update,
    input  logic [`EXEC_RW-1:0]  i_exec_pc,
    output int                   o_value_errors,
    output int                   o_other_errors
);

    logic [`EXEC_RW-1:0] data_q[$];
    logic [7:0]          ie_q[$];
    exec_pkg::flags_t    model_flags;
    logic [`EXEC_RW-1:0] model_pc;
    logic                exp_flush;
    logic                after_rst = 1'b0;
    logic                final_done = 1'b0;
    int                  accepted = 0;
    int                  submitted = 0;
    int                  value_errors = 0;
    int                  other_errors = 0;

    assign o_value_errors = value_errors;
    assign o_other_errors = other_errors;

    // Expected result with the five flags above it
    function automatic logic [`EXEC_RW+4:0] model_alu(input exec_pkg::alu_mode_t mode,
            input logic [`EXEC_RW-1:0] l, input logic [`EXEC_RW-1:0] r, input logic cin);
        int                  full;
        int                  sfull;
        int                  sh;
        logic [`EXEC_RW-1:0] res;
        logic                c;
        logic                v;
        exec_pkg::flags_t    f;
        c = 1'b0;
        v = 1'b0;
        sh = int'(r[3:0]);
        case (mode)
            exec_pkg::ADD: begin
                full  = int'(l) + int'(r) + int'(cin);
                sfull = int'($signed(l)) + int'($signed(r)) + int'(cin);
                res   = full[`EXEC_RW-1:0];
                c     = (full > 65535);
                v     = (sfull > 32767) || (sfull < -32768);
            end
            exec_pkg::SUB: begin
                // Carry means a borrow was needed
                full  = int'(l) - int'(r) - int'(cin);
                sfull = int'($signed(l)) - int'($signed(r)) - int'(cin);
                res   = full[`EXEC_RW-1:0];
                c     = (full < 0);
                v     = (sfull > 32767) || (sfull < -32768);
            end
            exec_pkg::AND: res = l & r;
            exec_pkg::OR:  res = l | r;
            exec_pkg::XOR: res = l ^ r;
            exec_pkg::SHL: begin
                res = l << sh;
                c   = (sh != 0) ? l[`EXEC_RW - sh] : 1'b0;
            end
            exec_pkg::SHR: begin
                res = l >> sh;
                c   = (sh != 0) ? l[sh - 1] : 1'b0;
            end
            default: res = r;
        endcase
        f                = '0;
        f[`EXEC_FLAG_C]  = c;
        f[`EXEC_FLAG_Z]  = (res == '0);
        f[`EXEC_FLAG_N]  = res[`EXEC_RW-1];
        f[`EXEC_FLAG_O]  = v;
        f[`EXEC_FLAG_P]  = ~^res;
        return {f, res};
    endfunction

    function automatic logic jump_taken(input exec_pkg::jump_code_t code,
            input exec_pkg::flags_t f);
        logic c;
        logic z;
        logic n;
        c = f[`EXEC_FLAG_C];
        z = f[`EXEC_FLAG_Z];
        n = f[`EXEC_FLAG_N];
        case (code)
            exec_pkg::UNCOND: return 1'b1;
            exec_pkg::CARRY:  return c;
            exec_pkg::EQUAL:  return z;
            exec_pkg::LT:     return n;
            exec_pkg::GT:     return !n && !z;
            exec_pkg::LE:     return n || z;
            exec_pkg::GE:     return !n;
            exec_pkg::NE:     return !z;
            exec_pkg::OVF:    return f[`EXEC_FLAG_O];
            exec_pkg::PAR:    return f[`EXEC_FLAG_P];
            exec_pkg::GTU:    return !c && !z;
            exec_pkg::GEU:    return !c;
            exec_pkg::LEU:    return c || z;
            default:          return 1'b0;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    always @(posedge i_clk) begin
        logic [`EXEC_RW+4:0] alu;
        logic [`EXEC_RW-1:0] r_bus;
        logic                fire;
        logic                exp_ready;
        logic                valid;
        logic                taken;
        if (i_rst) begin
            model_flags = '0;
            model_pc    = `EXEC_PC_RESET;
            exp_flush   = 1'b0;
            after_rst   = 1'b1;
            data_q.delete();
            ie_q.delete();
        end else begin
            if (after_rst && (!i_ready || i_out_submit || i_out_flush)) begin
                $display("At %0t the stage left reset busy or with a pulse on its outputs", $time);
                other_errors++;
            end
            after_rst = 1'b0;
            fire = i_submit & ~i_flush & i_next_ready;
            // Ready unless a live instruction waits on the next stage
            exp_ready = ~(i_submit & ~i_flush) | i_next_ready;
            check_val("o_ready", 32'(exp_ready), 32'(i_ready));
            check_val("o_pc_update", 32'(fire), 32'(i_pc_update));
            check_val("o_exec_pc", 32'(model_pc), 32'(i_exec_pc));
            check_val("o_flush", 32'(exp_flush), 32'(i_out_flush));
            if (i_submit && i_ready && !i_flush) begin
                accepted++;
            end
            if (i_out_submit) begin
                submitted++;
                if (data_q.size() == 0) begin
                    $display("At %0t o_submit pulsed with no executed instruction left", $time);
                    other_errors++;
                end else begin
                    check_val("o_data", 32'(data_q.pop_front()), 32'(i_data));
                    check_val("o_reg_ie", 32'(ie_q.pop_front()), 32'(i_reg_ie));
                end
            end
            // Model the execute edge from the inputs alone
            r_bus = i_r_bus_imm ? i_imm : i_r_operand;
            alu = model_alu(i_alu_mode, i_l_operand, r_bus,
                            model_flags[`EXEC_FLAG_C] & i_carry_en);
            valid = i_jump_code[`EXEC_JUMP_W-1];
            taken = jump_taken(i_jump_code, model_flags);
            exp_flush = fire & ((valid & (taken ^ i_jmp_predict)) | i_pc_ie);
            if (fire) begin
                data_q.push_back(alu[`EXEC_RW-1:0]);
                ie_q.push_back(i_rf_ie);
                if ((valid & taken) | i_pc_ie) begin
                    model_pc = alu[`EXEC_RW-1:0];
                end else if ((valid & ~taken) | i_pc_inc) begin
                    model_pc = model_pc + 16'd1;
                end
                if (i_flags_ie) begin
                    model_flags = alu[`EXEC_RW+4:`EXEC_RW];
                end
            end
            if (i_final && !final_done) begin
                final_done = 1'b1;
                if (submitted != accepted || data_q.size() != 0) begin
                    $display("Accepted %0d instructions but saw %0d o_submit pulses",
                             accepted, submitted);
                    other_errors++;
                end
            end
        end
    end

endmodule

/* verification/tb_exec_stage.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module tb_exec_stage;

    localparam int N_INSTR     = 400;
    localparam int CYCLE_LIMIT = 2 * N_INSTR + 200;

    logic                 i_clk = 1'b0;
    logic                 i_rst = 1'b1;
    logic                 i_submit = 1'b0;
    logic                 i_flush = 1'b0;
    logic                 i_next_ready = 1'b0;
    logic [`EXEC_RW-1:0]  i_l_operand = '0;
    logic [`EXEC_RW-1:0]  i_r_operand = '0;
    logic [`EXEC_RW-1:0]  i_imm = '0;
    logic                 c_r_bus_imm = 1'b0;
    logic                 c_alu_carry_en = 1'b0;
    logic                 c_alu_flags_ie = 1'b0;
    logic                 c_pc_inc = 1'b0;
    logic                 c_pc_ie = 1'b0;
    logic                 i_jmp_predict = 1'b0;
    exec_pkg::alu_mode_t  c_alu_mode = exec_pkg::PASS_R;
    exec_pkg::jump_code_t c_jump_code = exec_pkg::NONE;
    logic [7:0]           c_rf_ie = '0;
    logic                 o_ready;
    logic                 o_submit;
    logic [`EXEC_RW-1:0]  o_data;
    logic [7:0]           o_reg_ie;
    logic                 o_flush;
    logic                 o_pc_update;
    logic [`EXEC_RW-1:0]  o_exec_pc;

    integer seed = 32'hdfa3;
    int     issued = 0;
    int     cycles = 0;
    int     value_errors;
    int     other_errors;
    logic   final_req = 1'b0;
    logic   timed_out = 1'b0;

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
    end

    exec_stage UUT (.*);

    exec_checker u_checker (
        .i_clk(i_clk), .i_rst(i_rst), .i_final(final_req),
        .i_submit(i_submit), .i_flush(i_flush), .i_next_ready(i_next_ready),
        .i_l_operand(i_l_operand), .i_r_operand(i_r_operand), .i_imm(i_imm),
        .i_r_bus_imm(c_r_bus_imm), .i_carry_en(c_alu_carry_en), .i_flags_ie(c_alu_flags_ie),
        .i_pc_inc(c_pc_inc), .i_pc_ie(c_pc_ie), .i_jmp_predict(i_jmp_predict),
        .i_alu_mode(c_alu_mode), .i_jump_code(c_jump_code), .i_rf_ie(c_rf_ie),
        .i_ready(o_ready), .i_out_submit(o_submit), .i_data(o_data), .i_reg_ie(o_reg_ie),
        .i_out_flush(o_flush), .i_pc_update(o_pc_update), .i_exec_pc(o_exec_pc),
        .o_value_errors(value_errors), .o_other_errors(other_errors)
    );

    // Present a random instruction or leave an idle slot
    task automatic present_instr();
        logic [31:0] pick;
        logic [31:0] d;
        logic [31:0] e;
        pick = $random(seed);
        d = $random(seed);
        e = $random(seed);
        if (issued == N_INSTR || pick[2:0] == 3'd0) begin
            i_submit <= 1'b0;
            i_flush  <= 1'b0;
        end else begin
            issued = issued + 1;
            i_submit       <= 1'b1;
            i_flush        <= (pick[7:4] == 4'd0);
            // Small left operands make zero and equal results common
            i_l_operand    <= pick[28] ? {14'h0, d[1:0]} : d[15:0];
            i_r_operand    <= d[31:16];
            i_imm          <= e[15:0];
            c_rf_ie        <= e[23:16];
            c_r_bus_imm    <= pick[8];
            c_alu_carry_en <= pick[9];
            c_alu_flags_ie <= (pick[11:10] != 2'd0);
            c_alu_mode     <= exec_pkg::alu_mode_t'({1'b0, pick[14:12]});
            i_jmp_predict  <= pick[15];
            c_pc_ie        <= (pick[18:16] == 3'd0);
            c_pc_inc       <= pick[19];
            c_jump_code    <= pick[20] ? exec_pkg::jump_code_t'(5'h10 + 5'(pick[27:24] % 4'd13))
                                       : exec_pkg::NONE;
        end
    endtask

    always @(posedge i_clk) begin
        logic [31:0] rdy;
        if (!i_rst) begin
            rdy = $random(seed);
            i_next_ready <= (rdy[1:0] != 2'd0);
            if (!i_submit || o_ready) begin
                present_instr();
            end
        end
    end

    initial begin
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
        while (!(issued == N_INSTR && !i_submit) && !timed_out) begin
            @(posedge i_clk);
            if (cycles >= CYCLE_LIMIT) begin
                timed_out = 1'b1;
            end
        end
        repeat (3) @(posedge i_clk);
        final_req <= 1'b1;
        repeat (2) @(posedge i_clk);
        if (timed_out) begin
            $display("Timeout: run stopped after %0d cycles, %0d of %0d instructions issued",
                     cycles, issued, N_INSTR);
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (!timed_out && value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+include
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_branch_unit.sv
hdl/exec_pipe_ctrl.sv
hdl/exec_stage.sv
verification/exec_checker.sv
verification/tb_exec_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exec_stage
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
